/* all.f */
+incdir+verilog
verilog/rix_mem_pkg.sv
verilog/rix_disp_pkg.sv
verilog/rix_stream_fifo.sv
verilog/rix_read_arbiter.sv
verilog/rix_fb_reader.sv
verilog/rix_display_top.sv
test/rix_display_checker.sv
test/tb_rix_display.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rix_display
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= Checks failed
PASS_TEXT ?= All checks passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) verilog/rix_defines.svh
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG) || ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_rix_display.sv */
// Testbench top with clock, reset, random latency memory model, test sequence and timeout
`timescale 1ns/1ps
`default_nettype none

`include "rix_defines.svh"

module tb_rix_display;
    localparam int TEX_REQS    = 12;
    // Frames of 40, 64, 37, 50 and 48 pixels, and at most four beats per texture read
    localparam int TOTAL_BEATS = 40 + 64 + 37 + 50 + 48 + 4 * TEX_REQS;
    localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 2000;

    logic                       aclk = 1'b0;
    logic                       rst_n;
    logic                       swap_fb;
    rix_disp_pkg::fb_cmd_t      fb_cmd;
    logic                       fb_swapped;
    logic                       m_disp_valid;
    logic                       m_disp_ready = 1'b1;
    rix_disp_pkg::disp_beat_t   m_disp;
    logic                       s_tex_ar_valid;
    logic                       s_tex_ar_ready;
    rix_mem_pkg::port_ar_t      s_tex_ar;
    logic                       s_tex_r_valid;
    logic                       s_tex_r_ready = 1'b1;
    rix_mem_pkg::port_r_t       s_tex_r;
    logic                       m_ar_valid;
    logic                       m_ar_ready = 1'b0;
    rix_mem_pkg::mem_ar_t       m_ar;
    logic                       m_r_valid = 1'b0;
    logic                       m_r_ready;
    rix_mem_pkg::mem_r_t        m_r = '0;
    logic [2:0]                 test_id;
    logic                       test_end;
    logic                       disp_ready_rand;
    logic                       tex_ready_rand;
    logic [31:0]                rng;
    // Address, ID and length bits of each texture read
    logic [31:0]                tex_rand [TEX_REQS];
    int                         cycle = 0;
    int                         check_count;
    int                         fail_count;
    int                         tex_beats_owed = 0;
    int                         tex_beats_seen = 0;
    // Accepted memory requests and the cycle from which each one may answer
    rix_mem_pkg::mem_ar_t       req_q[$];
    int                         due_q[$];
    int                         beat_no = 0;

    rix_display_top dut (.*);

    rix_display_checker chk (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // The memory model takes its handshakes at the rising edge
    always @(posedge aclk)
    begin
        if (!rst_n)
        begin
            req_q.delete();
            due_q.delete();
            beat_no = 0;
        end
        else
        begin
            if (m_r_valid && m_r_ready)
            begin
                if (beat_no == int'(req_q[0].len))
                begin
                    void'(req_q.pop_front());
                    void'(due_q.pop_front());
                    beat_no = 0;
                end
                else
                    beat_no++;
            end
            if (m_ar_valid && m_ar_ready)
            begin
                req_q.push_back(m_ar);
                due_q.push_back(cycle + 2 + int'(next_rand() % 8));
            end
            if (s_tex_r_valid && s_tex_r_ready)
                tex_beats_seen++;
        end
    end

    // Answers come back in request order, each beat held until it is taken
    always @(negedge aclk)
    begin
        m_ar_ready    = (next_rand() % 4) != 0;
        m_disp_ready  = disp_ready_rand ? (next_rand() % 2) == 1 : 1'b1;
        s_tex_r_ready = tex_ready_rand ? (next_rand() % 3) != 0 : 1'b1;
        if (rst_n && req_q.size() != 0 && cycle >= due_q[0])
        begin
            m_r_valid = 1'b1;
            m_r       = '{id: req_q[0].id,
                          data: chk.mem_word(req_q[0].addr + 32'(4 * beat_no)),
                          last: beat_no == int'(req_q[0].len)};
        end
        else
            m_r_valid = 1'b0;
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge aclk);
    endtask

    task automatic start_frame(input logic [31:0] addr, input int size);
        @(negedge aclk);
        swap_fb = 1'b1;
        fb_cmd  = '{addr: addr, size: `RIX_FB_SIZE_LG'(size)};
        @(negedge aclk);
        swap_fb = 1'b0;
    endtask

    task automatic wait_swapped();
        @(posedge aclk);
        while (fb_swapped !== 1'b1)
            @(posedge aclk);
    endtask

    task automatic tex_read(input logic [31:0] addr, input logic [4:0] id, input logic [7:0] len);
        @(negedge aclk);
        s_tex_ar_valid = 1'b1;
        s_tex_ar       = '{id: id, addr: addr, len: len};
        tex_beats_owed += int'(len) + 1;
        @(posedge aclk);
        while (!s_tex_ar_ready)
            @(posedge aclk);
        @(negedge aclk);
        s_tex_ar_valid = 1'b0;
    endtask

    task automatic end_test();
        @(negedge aclk);
        test_end = 1'b1;
        @(negedge aclk);
        test_end = 1'b0;
        test_id  = test_id + 1'b1;
    endtask

    initial
    begin
        rng             = 32'hbba1f904;
        rst_n           = 1'b0;
        swap_fb         = 1'b0;
        fb_cmd          = '0;
        s_tex_ar_valid  = 1'b0;
        s_tex_ar        = '0;
        test_id         = 3'd1;
        test_end        = 1'b0;
        disp_ready_rand = 1'b0;
        tex_ready_rand  = 1'b0;
        for (int i = 0; i < TEX_REQS; i++)
            tex_rand[i] = next_rand();
        repeat (5) @(negedge aclk);
        rst_n = 1'b1;

        // The second swap lands while the first frame is still busy
        start_frame(32'h0002_0000, 40);
        idle_cycles(6);
        start_frame(32'h0003_0000, 24);
        wait_swapped();
        idle_cycles(40);
        end_test();

        start_frame(32'h0004_0000, 64);
        wait_swapped();
        end_test();

        start_frame(32'h0005_0100, 37);
        wait_swapped();
        end_test();

        disp_ready_rand = 1'b1;
        start_frame(32'h0006_0000, 50);
        wait_swapped();
        disp_ready_rand = 1'b0;
        end_test();

        tex_ready_rand = 1'b1;
        start_frame(32'h0007_0000, 48);
        fork
            wait_swapped();
            for (int i = 0; i < TEX_REQS; i++)
                tex_read({12'h001, tex_rand[i][17:0], 2'b00}, tex_rand[i][22:18],
                         {6'd0, tex_rand[i][24:23]});
        join
        while (tex_beats_seen != tex_beats_owed)
            @(negedge aclk);
        tex_ready_rand = 1'b0;
        end_test();

        idle_cycles(4);
        $display("Tests run: 5, checks: %0d, errors: %0d", check_count, fail_count);
        if (fail_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/rix_display_checker.sv */
// Scoreboard for the display read path with the memory content reference, stream and request checks
`timescale 1ns/1ps
`default_nettype none

`include "rix_defines.svh"

module rix_display_checker (
    input  wire                             aclk,
    input  wire                             rst_n,
    input  wire [2:0]                       test_id,
    input  wire                             test_end,
    input  wire                             swap_fb,
    input  wire rix_disp_pkg::fb_cmd_t      fb_cmd,
    input  wire                             fb_swapped,
    input  wire                             m_disp_valid,
    input  wire                             m_disp_ready,
    input  wire rix_disp_pkg::disp_beat_t   m_disp,
    input  wire                             s_tex_ar_valid,
    input  wire                             s_tex_ar_ready,
    input  wire rix_mem_pkg::port_ar_t      s_tex_ar,
    input  wire                             s_tex_r_valid,
    input  wire                             s_tex_r_ready,
    input  wire rix_mem_pkg::port_r_t       s_tex_r,
    input  wire                             m_ar_valid,
    input  wire                             m_ar_ready,
    input  wire rix_mem_pkg::mem_ar_t       m_ar,
    input  wire                             m_r_valid,
    input  wire                             m_r_ready,
    input  wire rix_mem_pkg::mem_r_t        m_r,
    output int                              check_count,
    output int                              fail_count
);
    localparam int TAG_MSB = `RIX_ID_WIDTH - 1;
    localparam int TAG_LSB = `RIX_ID_WIDTH - `RIX_PORT_TAG_BITS;
    localparam int PID_W   = `RIX_PORT_ID_WIDTH;

    logic           rst_seen = 1'b0;
    logic           active = 1'b0;
    logic           swap_due = 1'b0;
    logic [31:0]    base;
    int             frame_size;
    int             beat_idx;
    int             req_beats;
    int             checks_total = 0;
    int             errors_total = 0;
    int             test_checks = 0;
    int             test_errors = 0;
    // Texture requests not yet seen on the memory port, and texture beats still owed
    rix_mem_pkg::port_ar_t  tex_req_q[$];
    logic [PID_W + 32 : 0]  tex_beat_q[$];

    assign check_count = checks_total;
    assign fail_count  = errors_total;

    // Memory content is a fixed scramble of the byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] w;
        w = addr * 32'h9e37_79b1;
        return w ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "reset_idle";
            3'd2: return "frame_64";
            3'd3: return "frame_37";
            3'd4: return "random_ready";
            3'd5: return "texture_reads";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks_total++;
        test_checks++;
        if (exp !== act)
        begin
            errors_total++;
            test_errors++;
            $display("[FAIL] %s: %s expected %0h, actual %0h", test_name(test_id), what, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        checks_total++;
        test_checks++;
        errors_total++;
        test_errors++;
        $display("Error in test %s: %s", test_name(test_id), msg);
    endtask

    always @(posedge aclk)
    begin
        logic                   accept;
        int                     exp_len;
        rix_mem_pkg::port_ar_t  tex_req;
        logic [PID_W + 32 : 0]  tex_beat;
        if (!rst_n)
        begin
            // One reset edge is enough for the DUT to drive these low
            if (rst_seen)
            begin
                check_value("fb_swapped in reset", 64'd0, 64'(fb_swapped));
                check_value("m_disp_valid in reset", 64'd0, 64'(m_disp_valid));
                check_value("m_ar_valid in reset", 64'd0, 64'(m_ar_valid));
                check_value("s_tex_r_valid in reset", 64'd0, 64'(s_tex_r_valid));
                check_value("s_tex_ar_ready in reset", 64'd0, 64'(s_tex_ar_ready));
            end
            rst_seen = 1'b1;
            active   = 1'b0;
            swap_due = 1'b0;
            tex_req_q.delete();
            tex_beat_q.delete();
        end
        else
        begin
            accept = swap_fb && !active;
            if (fb_swapped !== swap_due)
                report_error(swap_due ? "fb_swapped did not pulse after the last pixel"
                                      : "fb_swapped pulsed with no frame finished");
            swap_due = 1'b0;
            if (m_disp_valid && m_disp_ready)
            begin
                if (!active)
                    report_error("display beat outside of a frame");
                else
                begin
                    check_value($sformatf("pixel %0d {data,last}", beat_idx),
                                {mem_word(base + 32'(4 * beat_idx)), beat_idx == frame_size - 1},
                                {m_disp.data, m_disp.last});
                    beat_idx++;
                    if (beat_idx == frame_size)
                    begin
                        active   = 1'b0;
                        swap_due = 1'b1;
                    end
                end
            end
            if (m_ar_valid && m_ar_ready)
            begin
                case (int'(m_ar.id[TAG_MSB:TAG_LSB]))
                    0:
                    begin
                        exp_len = frame_size - req_beats;
                        if (exp_len > `RIX_BURST_BEATS)
                            exp_len = `RIX_BURST_BEATS;
                        if (exp_len <= 0)
                            report_error("framebuffer request beyond the end of the frame");
                        else
                        begin
                            check_value("framebuffer request address",
                                        64'(base + 32'(4 * req_beats)), 64'(m_ar.addr));
                            check_value("framebuffer request len", 64'(exp_len - 1), 64'(m_ar.len));
                            req_beats += exp_len;
                        end
                    end
                    1:
                    begin
                        if (tex_req_q.size() == 0)
                            report_error("texture request on the memory port that was never issued");
                        else
                        begin
                            tex_req = tex_req_q.pop_front();
                            check_value("texture request {id,addr,len}", 64'(tex_req),
                                        {m_ar.id[PID_W - 1 : 0], m_ar.addr, m_ar.len});
                        end
                    end
                    default: report_error("memory request carries an unknown port tag");
                endcase
            end
            // A read beat takes the ready of its own port, and the reader never stalls one
            if (m_r_valid)
                check_value("memory read ready",
                            64'((m_r.id[TAG_MSB:TAG_LSB] == 3'd1) ? s_tex_r_ready : 1'b1),
                            64'(m_r_ready));
            if (s_tex_ar_valid && s_tex_ar_ready)
            begin
                tex_req_q.push_back(s_tex_ar);
                for (int k = 0; k <= int'(s_tex_ar.len); k++)
                    tex_beat_q.push_back({s_tex_ar.id, mem_word(s_tex_ar.addr + 32'(4 * k)),
                                          k == int'(s_tex_ar.len)});
            end
            if (s_tex_r_valid && s_tex_r_ready)
            begin
                if (tex_beat_q.size() == 0)
                    report_error("texture read beat with no read outstanding");
                else
                begin
                    tex_beat = tex_beat_q.pop_front();
                    check_value("texture beat {id,data,last}", 64'(tex_beat),
                                {s_tex_r.id, s_tex_r.data, s_tex_r.last});
                end
            end
            if (accept)
            begin
                active     = 1'b1;
                base       = fb_cmd.addr;
                frame_size = int'(fb_cmd.size);
                beat_idx   = 0;
                req_beats  = 0;
            end
            if (test_end)
            begin
                if (active)
                    report_error("frame not fully streamed when the test ended");
                if (tex_req_q.size() != 0 || tex_beat_q.size() != 0)
                    report_error("texture reads still outstanding when the test ended");
                if (test_errors == 0)
                    $display("Test %s passed, %0d checks", test_name(test_id), test_checks);
                else
                    $display("Test %s failed, %0d errors in %0d checks", test_name(test_id),
                             test_errors, test_checks);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rix_display_top.sv */
// Display read path top level joining the framebuffer reader and texture port on one memory port
`timescale 1ns/1ps
`default_nettype none

module rix_display_top (
    input  wire                             aclk,
    input  wire                             rst_n,
    input  wire                             swap_fb,
    input  wire rix_disp_pkg::fb_cmd_t      fb_cmd,
    output wire                             fb_swapped,
    output wire                             m_disp_valid,
    input  wire                             m_disp_ready,
    output wire rix_disp_pkg::disp_beat_t   m_disp,
    input  wire                             s_tex_ar_valid,
    output wire                             s_tex_ar_ready,
    input  wire rix_mem_pkg::port_ar_t      s_tex_ar,
    output wire                             s_tex_r_valid,
    input  wire                             s_tex_r_ready,
    output wire rix_mem_pkg::port_r_t       s_tex_r,
    output wire                             m_ar_valid,
    input  wire                             m_ar_ready,
    output wire rix_mem_pkg::mem_ar_t       m_ar,
    input  wire                             m_r_valid,
    output wire                             m_r_ready,
    input  wire rix_mem_pkg::mem_r_t        m_r
);
    // Reader side of the arbiter, port 0
    wire                            rd_ar_valid;
    wire                            rd_ar_ready;
    wire rix_mem_pkg::port_ar_t     rd_ar;
    wire                            rd_r_valid;
    wire                            rd_r_ready;
    wire rix_mem_pkg::port_r_t      rd_r;

    rix_fb_reader fb_reader (
        .aclk(aclk),
        .rst_n(rst_n),
        .swap_fb(swap_fb),
        .fb_cmd(fb_cmd),
        .fb_swapped(fb_swapped),
        .m_ar_valid(rd_ar_valid),
        .m_ar_ready(rd_ar_ready),
        .m_ar(rd_ar),
        .m_r_valid(rd_r_valid),
        .m_r_ready(rd_r_ready),
        .m_r(rd_r),
        .m_disp_valid(m_disp_valid),
        .m_disp_ready(m_disp_ready),
        .m_disp(m_disp)
    );

    // Texture port takes index 1
    rix_read_arbiter #(
        .N_PORTS(2)
    ) read_arbiter (
        .aclk(aclk),
        .rst_n(rst_n),
        .s_ar_valid({s_tex_ar_valid, rd_ar_valid}),
        .s_ar_ready({s_tex_ar_ready, rd_ar_ready}),
        .s_ar({s_tex_ar, rd_ar}),
        .s_r_valid({s_tex_r_valid, rd_r_valid}),
        .s_r_ready({s_tex_r_ready, rd_r_ready}),
        .s_r({s_tex_r, rd_r}),
        .m_ar_valid(m_ar_valid),
        .m_ar_ready(m_ar_ready),
        .m_ar(m_ar),
        .m_r_valid(m_r_valid),
        .m_r_ready(m_r_ready),
        .m_r(m_r)
    );

endmodule

`default_nettype wire

/* verilog/rix_fb_reader.sv */
// Framebuffer reader that bursts a swapped frame from memory onto the display stream
`timescale 1ns/1ps
`default_nettype none

`include "rix_defines.svh"

module rix_fb_reader (
    input  wire                             aclk,
    input  wire                             rst_n,
    input  wire                             swap_fb,
    input  wire rix_disp_pkg::fb_cmd_t      fb_cmd,
    output logic                            fb_swapped,
    output logic                            m_ar_valid,
    input  wire                             m_ar_ready,
    output rix_mem_pkg::port_ar_t           m_ar,
    input  wire                             m_r_valid,
    output logic                            m_r_ready,
    input  wire rix_mem_pkg::port_r_t       m_r,
    output logic                            m_disp_valid,
    input  wire                             m_disp_ready,
    output rix_disp_pkg::disp_beat_t        m_disp
);
    localparam int ADDR_W     = `RIX_ADDR_WIDTH;
    localparam int SIZE_W     = `RIX_FB_SIZE_LG;
    localparam int BURST      = `RIX_BURST_BEATS;
    localparam int FIFO_DEPTH = 2 * BURST;
    localparam int FREE_W     = $clog2(FIFO_DEPTH + 1);

    typedef enum logic {ST_IDLE, ST_BUSY} state_t;

    state_t                     state;
    logic [ADDR_W - 1 : 0]      next_addr;
    logic [SIZE_W - 1 : 0]      frame_size;
    logic [SIZE_W - 1 : 0]      req_left;
    logic [SIZE_W - 1 : 0]      recv_cnt;
    logic [SIZE_W - 1 : 0]      sent_cnt;
    logic [SIZE_W - 1 : 0]      burst_beats;
    logic [FREE_W - 1 : 0]      reserved;
    logic [FREE_W - 1 : 0]      fifo_free;
    logic                       issue;
    logic                       beat_in;
    logic                       disp_fire;
    rix_disp_pkg::disp_beat_t   fifo_in;

    assign burst_beats = (req_left > SIZE_W'(BURST)) ? SIZE_W'(BURST) : req_left;

    // Reserved beats are requested but not yet in the FIFO, so they already own slots
    assign issue = (state == ST_BUSY) && !m_ar_valid && (req_left != '0)
                && (fifo_free >= reserved + FREE_W'(BURST));

    assign m_r_ready = (state == ST_BUSY);
    assign beat_in   = m_r_valid && m_r_ready;
    assign disp_fire = m_disp_valid && m_disp_ready;
    assign fifo_in   = '{data: m_r.data, last: (recv_cnt == frame_size - 1'b1)};

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state      <= ST_IDLE;
            m_ar_valid <= 1'b0;
            fb_swapped <= 1'b0;
            req_left   <= '0;
            recv_cnt   <= '0;
            sent_cnt   <= '0;
            reserved   <= '0;
        end
        else
        begin
            fb_swapped <= 1'b0;
            if (m_ar_valid && m_ar_ready)
                m_ar_valid <= 1'b0;
            if (issue)
            begin
                m_ar_valid <= 1'b1;
                req_left   <= req_left - burst_beats;
            end
            reserved <= reserved + (issue ? FREE_W'(burst_beats) : '0)
                      - (beat_in ? FREE_W'(1) : '0);
            if (beat_in)
                recv_cnt <= recv_cnt + 1'b1;
            if (disp_fire)
                sent_cnt <= sent_cnt + 1'b1;

            case (state)
                ST_IDLE:
                begin
                    if (swap_fb)
                    begin
                        state    <= ST_BUSY;
                        req_left <= fb_cmd.size;
                        recv_cnt <= '0;
                        sent_cnt <= '0;
                    end
                end
                ST_BUSY:
                begin
                    // The frame is released only once its final pixel has left
                    if (disp_fire && (sent_cnt == frame_size - 1'b1))
                    begin
                        fb_swapped <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if ((state == ST_IDLE) && swap_fb)
        begin
            next_addr  <= fb_cmd.addr;
            frame_size <= fb_cmd.size;
        end
        if (issue)
        begin
            m_ar      <= '{id: '0, addr: next_addr, len: 8'(burst_beats - 1'b1)};
            next_addr <= next_addr + (ADDR_W'(burst_beats) << 2);
        end
    end

    rix_stream_fifo #(
        .payload_t(rix_disp_pkg::disp_beat_t),
        .DEPTH(FIFO_DEPTH)
    ) disp_fifo (
        .aclk(aclk),
        .rst_n(rst_n),
        .in_valid(beat_in),
        .in_ready(),
        .in_data(fifo_in),
        .out_valid(m_disp_valid),
        .out_ready(m_disp_ready),
        .out_data(m_disp),
        .free_slots(fifo_free)
    );

    a_no_beat_idle: assert property (@(posedge aclk) disable iff (!rst_n)
        m_r_valid |-> (state == ST_BUSY));

endmodule

`default_nettype wire

/* verilog/rix_read_arbiter.sv */
// Round-robin read request arbiter with port tagging of IDs and read beat routing
`timescale 1ns/1ps
`default_nettype none

`include "rix_defines.svh"

module rix_read_arbiter #(
    parameter int N_PORTS = 2
) (
    input  wire                                         aclk,
    input  wire                                         rst_n,
    input  wire [N_PORTS - 1 : 0]                       s_ar_valid,
    output logic [N_PORTS - 1 : 0]                      s_ar_ready,
    input  wire rix_mem_pkg::port_ar_t [N_PORTS - 1 : 0] s_ar,
    output logic [N_PORTS - 1 : 0]                      s_r_valid,
    input  wire [N_PORTS - 1 : 0]                       s_r_ready,
    output rix_mem_pkg::port_r_t [N_PORTS - 1 : 0]      s_r,
    output logic                                        m_ar_valid,
    input  wire                                         m_ar_ready,
    output rix_mem_pkg::mem_ar_t                        m_ar,
    input  wire                                         m_r_valid,
    output logic                                        m_r_ready,
    input  wire rix_mem_pkg::mem_r_t                    m_r
);
    localparam int TAG_W = `RIX_PORT_TAG_BITS;
    localparam int ID_W  = `RIX_ID_WIDTH;
    localparam int PID_W = `RIX_PORT_ID_WIDTH;

    logic [TAG_W - 1 : 0]   rr_ptr;
    logic [TAG_W - 1 : 0]   grant_idx;
    logic [TAG_W - 1 : 0]   r_tag;
    logic                   grant_valid;
    logic                   fifo_in_ready;
    logic                   ar_push;
    rix_mem_pkg::mem_ar_t   fifo_in;

    // Search starts at the port after the last winner
    always_comb
    begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < N_PORTS; i++)
        begin
            idx = int'(rr_ptr) + i;
            if (idx >= N_PORTS)
                idx = idx - N_PORTS;
            if (!grant_valid && s_ar_valid[idx])
            begin
                grant_valid = 1'b1;
                grant_idx   = TAG_W'(idx);
            end
        end
    end

    always_comb
    begin
        for (int p = 0; p < N_PORTS; p++)
            s_ar_ready[p] = grant_valid && fifo_in_ready && (grant_idx == TAG_W'(p));
    end

    assign ar_push = grant_valid && fifo_in_ready;
    assign fifo_in = '{id: {grant_idx, s_ar[grant_idx].id},
                       addr: s_ar[grant_idx].addr,
                       len: s_ar[grant_idx].len};

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
            rr_ptr <= '0;
        else if (ar_push)
            rr_ptr <= (grant_idx == TAG_W'(N_PORTS - 1)) ? '0 : grant_idx + 1'b1;
    end

    rix_stream_fifo #(
        .payload_t(rix_mem_pkg::mem_ar_t),
        .DEPTH(2)
    ) ar_fifo (
        .aclk(aclk),
        .rst_n(rst_n),
        .in_valid(ar_push),
        .in_ready(fifo_in_ready),
        .in_data(fifo_in),
        .out_valid(m_ar_valid),
        .out_ready(m_ar_ready),
        .out_data(m_ar),
        .free_slots()
    );

    // Beats go back to the port named by the upper ID bits, tag stripped
    assign r_tag = m_r.id[ID_W - 1 -: TAG_W];

    always_comb
    begin
        m_r_ready = 1'b0;
        for (int p = 0; p < N_PORTS; p++)
        begin
            s_r_valid[p] = m_r_valid && (r_tag == TAG_W'(p));
            s_r[p]       = '{id: m_r.id[PID_W - 1 : 0], data: m_r.data, last: m_r.last};
            if (r_tag == TAG_W'(p))
                m_r_ready = s_r_ready[p];
        end
    end

    a_tag_range: assert property (@(posedge aclk) disable iff (!rst_n)
        m_r_valid |-> (int'(r_tag) < N_PORTS));

    for (genvar p = 0; p < N_PORTS; p++)
    begin : g_hold_chk
        a_req_stable: assert property (@(posedge aclk) disable iff (!rst_n)
            s_ar_valid[p] && !s_ar_ready[p] |=> s_ar_valid[p] && $stable(s_ar[p]));
    end

endmodule

`default_nettype wire

/* verilog/rix_stream_fifo.sv */
// Synchronous valid/ready FIFO with a type-parameterized payload and free-slot count
`timescale 1ns/1ps
`default_nettype none

module rix_stream_fifo #(
    parameter type payload_t = logic,
    // Must be at least 2
    parameter int  DEPTH     = 4
) (
    input  wire                               aclk,
    input  wire                               rst_n,
    input  wire                               in_valid,
    output logic                              in_ready,
    input  wire payload_t                     in_data,
    output logic                              out_valid,
    input  wire                               out_ready,
    output payload_t                          out_data,
    output logic [$clog2(DEPTH + 1) - 1 : 0]  free_slots
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W - 1:0] wr_ptr;
    logic [PTR_W - 1:0] rd_ptr;
    logic [CNT_W - 1:0] count;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W - 1:0] ptr_inc(input logic [PTR_W - 1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push       = in_valid && in_ready;
    assign pop        = out_valid && out_ready;
    assign in_ready   = (count != CNT_W'(DEPTH));
    assign out_valid  = (count != '0);
    assign out_data   = mem[rd_ptr];
    assign free_slots = CNT_W'(DEPTH) - count;

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (!push && pop)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    // A write offered while full has to wait with its data, otherwise the beat is lost
    a_no_overflow: assert property (@(posedge aclk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

`default_nettype wire

/* verilog/rix_disp_pkg.sv */
// Framebuffer swap command and display stream beat types
`default_nettype none

`include "rix_defines.svh"

package rix_disp_pkg;

    // Start byte address and pixel count of the frame to be shown
    typedef struct packed {
        logic [`RIX_ADDR_WIDTH - 1 : 0]     addr;
        logic [`RIX_FB_SIZE_LG - 1 : 0]     size;
    } fb_cmd_t;

    // One pixel on the display stream, last marks the final pixel of the frame
    typedef struct packed {
        logic [`RIX_DATA_WIDTH - 1 : 0]     data;
        logic                               last;
    } disp_beat_t;

endpackage

`default_nettype wire

/* verilog/rix_mem_pkg.sv */
// Memory read request and read beat types, memory side and port side
`default_nettype none

`include "rix_defines.svh"

package rix_mem_pkg;

    // Read request as it leaves the arbiter, len is beats minus one
    typedef struct packed {
        logic [`RIX_ID_WIDTH - 1 : 0]       id;
        logic [`RIX_ADDR_WIDTH - 1 : 0]     addr;
        logic [7 : 0]                       len;
    } mem_ar_t;

    typedef struct packed {
        logic [`RIX_PORT_ID_WIDTH - 1 : 0]  id;
        logic [`RIX_ADDR_WIDTH - 1 : 0]     addr;
        logic [7 : 0]                       len;
    } port_ar_t;

    // One beat of read data
    typedef struct packed {
        logic [`RIX_ID_WIDTH - 1 : 0]       id;
        logic [`RIX_DATA_WIDTH - 1 : 0]     data;
        logic                               last;
    } mem_r_t;

    typedef struct packed {
        logic [`RIX_PORT_ID_WIDTH - 1 : 0]  id;
        logic [`RIX_DATA_WIDTH - 1 : 0]     data;
        logic                               last;
    } port_r_t;

endpackage

`default_nettype wire

/* verilog/rix_defines.svh */
// Bus widths, memory ID split, frame size width and burst length for the display read path
`ifndef RIX_DEFINES_SVH
`define RIX_DEFINES_SVH

// Byte address width of the memory port
`define RIX_ADDR_WIDTH 32

// Memory word width, one pixel per word
`define RIX_DATA_WIDTH 32

// ID width on the memory side of the arbiter
`define RIX_ID_WIDTH 8

// Upper ID bits that carry the requesting port index
`define RIX_PORT_TAG_BITS 3

// ID width seen by each port
`define RIX_PORT_ID_WIDTH (`RIX_ID_WIDTH - `RIX_PORT_TAG_BITS)

// Width of the frame size in pixels
`define RIX_FB_SIZE_LG 20

// Longest read burst in beats
`define RIX_BURST_BEATS 16

`endif
